// ==== verilog/ioFabricPkg.sv ====
package ioFabricPkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths

  parameter int AddrWidth = 38;
  parameter int DataWidth = 64;
  // largest device mask, the PLIC's
  parameter int OffsetWidth = 22;

  typedef enum logic {
    OpRead,
    OpWrite
  } ioOpE;

  // error sink sits at index 0
  typedef enum logic [1:0] {
    DevErr,
    DevClint,
    DevPlic
  } ioDevE;

  //////////////////////////////////////////////////////////////////////
  // address windows

  parameter logic [AddrWidth-1:0] ClintBaseAddr = 'h11400000;
  parameter logic [AddrWidth-1:0] ClintBaseMask = 'h0000FFFF;

  parameter logic [AddrWidth-1:0] PlicBaseAddr = 'h11000000;
  parameter logic [AddrWidth-1:0] PlicBaseMask = 'h003FFFFF;

  //////////////////////////////////////////////////////////////////////
  // register offsets inside a window

  parameter logic [OffsetWidth-1:0] ClintMsipOffset = 'h0000;
  parameter int ClintMsipStride = 4;
  parameter logic [OffsetWidth-1:0] ClintMtimecmpOffset = 'h4000;
  parameter int ClintMtimecmpStride = 8;
  parameter logic [OffsetWidth-1:0] ClintMtimeOffset = 'hBFF8;

  parameter logic [OffsetWidth-1:0] PlicPendingOffset = 'h1000;
  parameter logic [OffsetWidth-1:0] PlicEnableOffset = 'h2000;
  parameter int PlicEnableStride = 'h80;
  parameter logic [OffsetWidth-1:0] PlicClaimOffset = 'h200004;
  parameter int PlicClaimStride = 'h1000;

endpackage

// ==== verilog/ioAddrDecode.sv ====
`timescale 1ns/1ps

module ioAddrDecode import ioFabricPkg::*; (
  input  logic                   clk_i,
  input  logic                   rstN_i,
  input  logic                   reqValid_i,
  input  ioOpE                   reqOp_i,
  input  logic [AddrWidth-1:0]   reqAddr_i,
  input  logic [DataWidth-1:0]   reqWdata_i,
  output logic                   decValid_o,
  output ioOpE                   decOp_o,
  output ioDevE                  decDev_o,
  output logic [OffsetWidth-1:0] decOffset_o,
  output logic [DataWidth-1:0]   decWdata_o
);

  logic                   clintMatch;
  logic                   plicMatch;
  ioDevE                  dev;
  logic [OffsetWidth-1:0] offset;

  // window match, same base/mask scheme as the socket
  always_comb begin
    clintMatch = (reqAddr_i & ~ClintBaseMask) == ClintBaseAddr;
    plicMatch  = (reqAddr_i & ~PlicBaseMask) == PlicBaseAddr;
    if (clintMatch) begin
      dev    = DevClint;
      offset = OffsetWidth'(reqAddr_i & ClintBaseMask);
    end else if (plicMatch) begin
      dev    = DevPlic;
      offset = OffsetWidth'(reqAddr_i & PlicBaseMask);
    end else begin
      // falls through to the error sink
      dev    = DevErr;
      offset = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      decValid_o <= 1'b0;
    end else begin
      decValid_o <= reqValid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    decOp_o     <= reqOp_i;
    decDev_o    <= dev;
    decOffset_o <= offset;
    decWdata_o  <= reqWdata_i;
  end

  addrKnown: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    reqValid_i |-> !$isunknown(reqAddr_i)
  );

endmodule

// ==== verilog/clintRegs.sv ====
`timescale 1ns/1ps

module clintRegs import ioFabricPkg::*; #(
  parameter int NumHarts    = 2,
  parameter int TimerDivide = 4
) (
  input  logic                   clk_i,
  input  logic                   rstN_i,
  input  logic                   selValid_i,
  input  ioOpE                   decOp_i,
  input  logic [OffsetWidth-1:0] decOffset_i,
  input  logic [DataWidth-1:0]   decWdata_i,
  output logic [DataWidth-1:0]   rdata_o,
  output logic [NumHarts-1:0]    irqSoftware_o,
  output logic [NumHarts-1:0]    irqTimer_o
);

  localparam int PreWidth = (TimerDivide > 1) ? $clog2(TimerDivide) : 1;

  logic [PreWidth-1:0]                 prescaler;
  logic                                tick;
  logic [DataWidth-1:0]                mtime;
  logic [NumHarts-1:0][DataWidth-1:0]  mtimecmp;
  logic [NumHarts-1:0]                 msip;
  logic [NumHarts-1:0]                 msipHit;
  logic [NumHarts-1:0]                 cmpHit;
  logic [NumHarts-1:0]                 timerCmp;
  logic                                wrEn;

  assign tick = prescaler == PreWidth'(TimerDivide - 1);
  assign wrEn = selValid_i && decOp_i == OpWrite;

  //////////////////////////////////////////////////////////////////////
  // offset decode and read data

  always_comb begin
    rdata_o = '0;
    for (int h = 0; h < NumHarts; h++) begin
      msipHit[h]  = decOffset_i == ClintMsipOffset + OffsetWidth'(ClintMsipStride * h);
      cmpHit[h]   = decOffset_i == ClintMtimecmpOffset + OffsetWidth'(ClintMtimecmpStride * h);
      timerCmp[h] = mtime >= mtimecmp[h];
      if (decOp_i == OpRead && msipHit[h]) begin
        rdata_o = DataWidth'(msip[h]);
      end
      if (decOp_i == OpRead && cmpHit[h]) begin
        rdata_o = mtimecmp[h];
      end
    end
    if (decOp_i == OpRead && decOffset_i == ClintMtimeOffset) begin
      rdata_o = mtime;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // timer and registers

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      prescaler     <= '0;
      mtime         <= '0;
      mtimecmp      <= '1;
      msip          <= '0;
      irqSoftware_o <= '0;
      irqTimer_o    <= '0;
    end else begin
      // mtime advances once per TimerDivide clocks
      if (tick) begin
        prescaler <= '0;
        mtime     <= mtime + 1'b1;
      end else begin
        prescaler <= prescaler + 1'b1;
      end
      for (int h = 0; h < NumHarts; h++) begin
        if (wrEn && msipHit[h]) begin
          msip[h] <= decWdata_i[0];
        end
        if (wrEn && cmpHit[h]) begin
          mtimecmp[h] <= decWdata_i;
        end
      end
      irqSoftware_o <= msip;
      irqTimer_o    <= timerCmp;
    end
  end

  mtimeMonotonic: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    $past(rstN_i) |-> mtime >= $past(mtime)
  );

endmodule

// ==== verilog/plicRegs.sv ====
`timescale 1ns/1ps

module plicRegs import ioFabricPkg::*; #(
  parameter int NumHarts = 2,
  parameter int NumIrqs  = 8
) (
  input  logic                   clk_i,
  input  logic                   rstN_i,
  input  logic                   selValid_i,
  input  ioOpE                   decOp_i,
  input  logic [OffsetWidth-1:0] decOffset_i,
  input  logic [DataWidth-1:0]   decWdata_i,
  input  logic [NumIrqs-1:0]     irqSrc_i,
  output logic [DataWidth-1:0]   rdata_o,
  output logic [NumHarts-1:0]    irqExternal_o
);

  localparam int IdWidth = (NumIrqs > 1) ? $clog2(NumIrqs) : 1;

  logic [NumIrqs-1:0]                 pending;
  logic [NumIrqs-1:0]                 inService;
  logic [NumHarts-1:0][NumIrqs-1:0]   enable;
  logic [NumHarts-1:0][IdWidth-1:0]   claimId;
  logic [NumHarts-1:0]                enableHit;
  logic [NumHarts-1:0]                claimHit;
  logic [NumHarts-1:0]                irqNext;
  logic [IdWidth-1:0]                 claimIdSel;
  logic                               claimRead;
  logic                               claimWrite;

  // level gateway, source 0 is reserved
  assign pending = irqSrc_i & ~inService & ~NumIrqs'(1);

  assign claimRead  = selValid_i && decOp_i == OpRead && |claimHit;
  assign claimWrite = selValid_i && decOp_i == OpWrite && |claimHit;

  //////////////////////////////////////////////////////////////////////
  // per-context decode and arbitration

  always_comb begin
    claimIdSel = '0;
    for (int c = 0; c < NumHarts; c++) begin
      enableHit[c] = decOffset_i == PlicEnableOffset + OffsetWidth'(PlicEnableStride * c);
      claimHit[c]  = decOffset_i == PlicClaimOffset + OffsetWidth'(PlicClaimStride * c);
      irqNext[c]   = |(pending & enable[c]);
      // lowest-numbered source wins, so scan downwards
      claimId[c] = '0;
      for (int s = NumIrqs - 1; s >= 1; s--) begin
        if (pending[s] && enable[c][s]) begin
          claimId[c] = IdWidth'(s);
        end
      end
      if (claimHit[c]) begin
        claimIdSel = claimId[c];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (decOp_i == OpRead) begin
      if (decOffset_i == PlicPendingOffset) begin
        rdata_o = DataWidth'(pending);
      end
      for (int c = 0; c < NumHarts; c++) begin
        if (enableHit[c]) begin
          rdata_o = DataWidth'(enable[c]);
        end
      end
      if (|claimHit) begin
        rdata_o = DataWidth'(claimIdSel);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // enables, claim/complete and irq outputs

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      enable        <= '0;
      inService     <= '0;
      irqExternal_o <= '0;
    end else begin
      irqExternal_o <= irqNext;
      for (int c = 0; c < NumHarts; c++) begin
        if (selValid_i && decOp_i == OpWrite && enableHit[c]) begin
          enable[c] <= decWdata_i[NumIrqs-1:0] & ~NumIrqs'(1);
        end
      end
      if (claimRead && claimIdSel != '0) begin
        inService[claimIdSel] <= 1'b1;
      end
      // completion clears the written ID
      if (claimWrite && decWdata_i < DataWidth'(NumIrqs)) begin
        inService[decWdata_i[IdWidth-1:0]] <= 1'b0;
      end
    end
  end

  claimInRange: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    claimRead |-> rdata_o < DataWidth'(NumIrqs)
  );

  claimedNotPending: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    claimRead && claimIdSel != '0 |=> !pending[$past(claimIdSel)]
  );

endmodule

// ==== verilog/ioRespMux.sv ====
`timescale 1ns/1ps

module ioRespMux import ioFabricPkg::*; (
  input  logic                 clk_i,
  input  logic                 rstN_i,
  input  logic                 decValid_i,
  input  ioDevE                decDev_i,
  input  logic [DataWidth-1:0] clintRdata_i,
  input  logic [DataWidth-1:0] plicRdata_i,
  output logic                 respValid_o,
  output logic [DataWidth-1:0] respData_o,
  output logic                 respErr_o
);

  logic [DataWidth-1:0] selData;

  // error sink answers with zero data
  always_comb begin
    case (decDev_i)
      DevClint: selData = clintRdata_i;
      DevPlic:  selData = plicRdata_i;
      default:  selData = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      respValid_o <= 1'b0;
      respErr_o   <= 1'b0;
    end else begin
      respValid_o <= decValid_i;
      respErr_o   <= decValid_i && decDev_i == DevErr;
    end
  end

  always_ff @(posedge clk_i) begin
    respData_o <= selData;
  end

  errWithValid: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    respErr_o |-> respValid_o
  );

endmodule

// ==== verilog/ioFabricTop.sv ====
`timescale 1ns/1ps

module ioFabricTop import ioFabricPkg::*; #(
  parameter int NumHarts    = 2,
  parameter int NumIrqs     = 8,
  parameter int TimerDivide = 4
) (
  input  logic                 clk_i,
  input  logic                 rstN_i,
  input  logic                 reqValid_i,
  input  ioOpE                 reqOp_i,
  input  logic [AddrWidth-1:0] reqAddr_i,
  input  logic [DataWidth-1:0] reqWdata_i,
  // uart on 1, sd on 2
  input  logic [NumIrqs-1:0]   irqSrc_i,
  output logic                 respValid_o,
  output logic [DataWidth-1:0] respData_o,
  output logic                 respErr_o,
  output logic [NumHarts-1:0]  irqSoftware_o,
  output logic [NumHarts-1:0]  irqTimer_o,
  output logic [NumHarts-1:0]  irqExternal_o
);

  logic                   decValid;
  ioOpE                   decOp;
  ioDevE                  decDev;
  logic [OffsetWidth-1:0] decOffset;
  logic [DataWidth-1:0]   decWdata;
  logic [DataWidth-1:0]   clintRdata;
  logic [DataWidth-1:0]   plicRdata;
  logic                   clintSel;
  logic                   plicSel;

  assign clintSel = decValid && decDev == DevClint;
  assign plicSel  = decValid && decDev == DevPlic;

  ioAddrDecode addrDecode_i (
    .clk_i       (clk_i),
    .rstN_i      (rstN_i),
    .reqValid_i  (reqValid_i),
    .reqOp_i     (reqOp_i),
    .reqAddr_i   (reqAddr_i),
    .reqWdata_i  (reqWdata_i),
    .decValid_o  (decValid),
    .decOp_o     (decOp),
    .decDev_o    (decDev),
    .decOffset_o (decOffset),
    .decWdata_o  (decWdata)
  );

  clintRegs #(
    .NumHarts    (NumHarts),
    .TimerDivide (TimerDivide)
  ) clint_i (
    .clk_i         (clk_i),
    .rstN_i        (rstN_i),
    .selValid_i    (clintSel),
    .decOp_i       (decOp),
    .decOffset_i   (decOffset),
    .decWdata_i    (decWdata),
    .rdata_o       (clintRdata),
    .irqSoftware_o (irqSoftware_o),
    .irqTimer_o    (irqTimer_o)
  );

  plicRegs #(
    .NumHarts (NumHarts),
    .NumIrqs  (NumIrqs)
  ) plic_i (
    .clk_i         (clk_i),
    .rstN_i        (rstN_i),
    .selValid_i    (plicSel),
    .decOp_i       (decOp),
    .decOffset_i   (decOffset),
    .decWdata_i    (decWdata),
    .irqSrc_i      (irqSrc_i),
    .rdata_o       (plicRdata),
    .irqExternal_o (irqExternal_o)
  );

  ioRespMux respMux_i (
    .clk_i        (clk_i),
    .rstN_i       (rstN_i),
    .decValid_i   (decValid),
    .decDev_i     (decDev),
    .clintRdata_i (clintRdata),
    .plicRdata_i  (plicRdata),
    .respValid_o  (respValid_o),
    .respData_o   (respData_o),
    .respErr_o    (respErr_o)
  );

endmodule

// ==== testbench/ioFabricTbUtil.svh ====
logic [15:0] lfsrState = 16'd14572;

// fibonacci lfsr with taps 16 14 13 11
function automatic logic [63:0] randBits(input int n);
  logic [63:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    r = {r[62:0], fb};
  end
  return r;
endfunction

task automatic checkVal(input string name, input logic [63:0] expVal,
                        input logic [63:0] gotVal);
  if (gotVal !== expVal) begin
    failRun($sformatf("MISMATCH at %0t: %s expected %h got %h",
                      $time, name, expVal, gotVal));
  end
endtask

//////////////////////////////////////////////////////////////////////
// reference model

logic [NumHarts-1:0]  mMsip;
logic [DataWidth-1:0] mCmp [NumHarts];
logic [NumIrqs-1:0]   mEnable [NumHarts];
logic [NumIrqs-1:0]   mInSvc;

function automatic void modelReset();
  mMsip  = '0;
  mInSvc = '0;
  for (int h = 0; h < NumHarts; h++) begin
    mCmp[h]    = '1;
    mEnable[h] = '0;
  end
endfunction

function automatic logic [NumIrqs-1:0] modelPending();
  return irqSrc & ~mInSvc & ~NumIrqs'(1);
endfunction

function automatic logic [NumHarts-1:0] modelExt();
  logic [NumHarts-1:0] v;
  v = '0;
  for (int c = 0; c < NumHarts; c++) begin
    v[c] = |(modelPending() & mEnable[c]);
  end
  return v;
endfunction

// mtime as seen in the decode cycle of a request issued now
function automatic logic [DataWidth-1:0] modelMtime();
  return DataWidth'((cycle + 1) / TimerDivide);
endfunction

function automatic logic [AddrWidth-1:0] clintAddr(input int off);
  return ClintBaseAddr + AddrWidth'(off);
endfunction

function automatic logic [AddrWidth-1:0] plicAddr(input int off);
  return PlicBaseAddr + AddrWidth'(off);
endfunction

function automatic logic [AddrWidth-1:0] unmappedAddr();
  logic [AddrWidth-1:0] a;
  a = AddrWidth'(randBits(AddrWidth));
  // top bit lies above both windows
  if ((a & ~ClintBaseMask) == ClintBaseAddr || (a & ~PlicBaseMask) == PlicBaseAddr) begin
    a[AddrWidth-1] = 1'b1;
  end
  return a;
endfunction

function automatic void modelAccess(input ioOpE op, input logic [AddrWidth-1:0] addr,
    input logic [DataWidth-1:0] wdata, output logic [DataWidth-1:0] rd, output logic err);
  logic [AddrWidth-1:0] off;
  logic [NumIrqs-1:0]   pend;
  int                   id;
  rd   = '0;
  err  = 1'b0;
  pend = modelPending();
  if ((addr & ~ClintBaseMask) == ClintBaseAddr) begin
    off = addr & ClintBaseMask;
    if (op == OpRead && off == ClintMtimeOffset) begin
      rd = modelMtime();
    end
    for (int h = 0; h < NumHarts; h++) begin
      if (off == ClintMsipOffset + ClintMsipStride * h) begin
        if (op == OpRead) begin
          rd = DataWidth'(mMsip[h]);
        end else begin
          mMsip[h] = wdata[0];
        end
      end
      if (off == ClintMtimecmpOffset + ClintMtimecmpStride * h) begin
        if (op == OpRead) begin
          rd = mCmp[h];
        end else begin
          mCmp[h] = wdata;
        end
      end
    end
  end else if ((addr & ~PlicBaseMask) == PlicBaseAddr) begin
    off = addr & PlicBaseMask;
    if (op == OpRead && off == PlicPendingOffset) begin
      rd = DataWidth'(pend);
    end
    for (int c = 0; c < NumHarts; c++) begin
      if (off == PlicEnableOffset + PlicEnableStride * c) begin
        if (op == OpRead) begin
          rd = DataWidth'(mEnable[c]);
        end else begin
          mEnable[c] = wdata[NumIrqs-1:0] & ~NumIrqs'(1);
        end
      end
      if (off == PlicClaimOffset + PlicClaimStride * c) begin
        if (op == OpRead) begin
          id = 0;
          for (int s = 1; s < NumIrqs; s++) begin
            if (id == 0 && pend[s] && mEnable[c][s]) begin
              id = s;
            end
          end
          rd = DataWidth'(id);
          if (id != 0) begin
            mInSvc[id] = 1'b1;
          end
        end else if (wdata < NumIrqs) begin
          mInSvc[int'(wdata)] = 1'b0;
        end
      end
    end
  end else begin
    err = 1'b1;
  end
endfunction

// ==== testbench/ioFabricTb.sv ====
`timescale 1ns/1ps

module ioFabricTb import ioFabricPkg::*; ();

  localparam int NumHarts    = 2;
  localparam int NumIrqs     = 8;
  localparam int TimerDivide = 4;

  logic                 clk;
  logic                 rstN;
  logic                 reqValid;
  ioOpE                 reqOp;
  logic [AddrWidth-1:0] reqAddr;
  logic [DataWidth-1:0] reqWdata;
  logic [NumIrqs-1:0]   irqSrc;
  logic                 respValid;
  logic [DataWidth-1:0] respData;
  logic                 respErr;
  logic [NumHarts-1:0]  irqSoftware;
  logic [NumHarts-1:0]  irqTimer;
  logic [NumHarts-1:0]  irqExternal;

  int                   cycle = 0;
  logic [DataWidth-1:0] expData [$];
  logic                 expErr [$];
  int                   expCycle [$];

  task automatic failRun(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  `include "ioFabricTbUtil.svh"

  ioFabricTop #(
    .NumHarts    (NumHarts),
    .NumIrqs     (NumIrqs),
    .TimerDivide (TimerDivide)
  ) dut_i (
    .clk_i         (clk),
    .rstN_i        (rstN),
    .reqValid_i    (reqValid),
    .reqOp_i       (reqOp),
    .reqAddr_i     (reqAddr),
    .reqWdata_i    (reqWdata),
    .irqSrc_i      (irqSrc),
    .respValid_o   (respValid),
    .respData_o    (respData),
    .respErr_o     (respErr),
    .irqSoftware_o (irqSoftware),
    .irqTimer_o    (irqTimer),
    .irqExternal_o (irqExternal)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (rstN) begin
      cycle <= cycle + 1;
    end
  end

  // response due two cycles after its request
  always @(negedge clk) begin
    if (rstN) begin
      if (expCycle.size() > 0 && expCycle[0] + 2 == cycle) begin
        checkVal("respValid_o", 64'(1), 64'(respValid));
        checkVal("respErr_o", 64'(expErr[0]), 64'(respErr));
        checkVal("respData_o", expData[0], respData);
        void'(expData.pop_front());
        void'(expErr.pop_front());
        void'(expCycle.pop_front());
      end else begin
        checkVal("respValid_o", 64'(0), 64'(respValid));
      end
    end
  end

  task automatic sendReq(input ioOpE op, input logic [AddrWidth-1:0] addr,
                         input logic [DataWidth-1:0] wdata);
    logic [DataWidth-1:0] rd;
    logic                 err;
    modelAccess(op, addr, wdata, rd, err);
    expData.push_back(rd);
    expErr.push_back(err);
    expCycle.push_back(cycle);
    reqValid = 1'b1;
    reqOp    = op;
    reqAddr  = addr;
    reqWdata = wdata;
    @(negedge clk);
    reqValid = 1'b0;
  endtask

  task automatic drain();
    for (int i = 0; i < 10 && expCycle.size() > 0; i++) begin
      @(negedge clk);
    end
    if (expCycle.size() > 0) begin
      failRun("timeout, responses still outstanding");
    end
  endtask

  function automatic logic [NumHarts-1:0] irqVec(input int kind);
    case (kind)
      0:       return irqSoftware;
      1:       return irqTimer;
      default: return irqExternal;
    endcase
  endfunction

  task automatic waitIrqs(input string name, input int kind, input logic [NumHarts-1:0] want);
    for (int i = 0; i < 20 && irqVec(kind) !== want; i++) begin
      @(negedge clk);
    end
    if (irqVec(kind) !== want) begin
      failRun($sformatf("timeout, %s never reached %b", name, want));
    end
  endtask

  initial begin
    int                   h;
    ioOpE                 op;
    logic [AddrWidth-1:0] a;
    clk      = 1'b0;
    rstN     = 1'b0;
    reqValid = 1'b0;
    reqOp    = OpRead;
    reqAddr  = '0;
    reqWdata = '0;
    irqSrc   = '0;
    modelReset();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // error sink, then msip

    for (int i = 0; i < 6; i++) begin
      sendReq(randBits(1) ? OpWrite : OpRead, unmappedAddr(), randBits(64));
    end
    drain();
    for (int i = 0; i < NumHarts; i++) begin
      sendReq(OpWrite, clintAddr(ClintMsipOffset + ClintMsipStride * i), randBits(64) | 64'h1);
      sendReq(OpRead, clintAddr(ClintMsipOffset + ClintMsipStride * i), '0);
    end
    drain();
    waitIrqs("irqSoftware_o", 0, mMsip);
    sendReq(OpWrite, clintAddr(ClintMsipOffset), randBits(64) & ~64'h1);
    sendReq(OpRead, clintAddr(ClintMsipOffset), '0);
    drain();
    waitIrqs("irqSoftware_o", 0, mMsip);

    //////////////////////////////////////////////////////////////////////
    // timer compare and mtime

    for (int i = 0; i < NumHarts; i++) begin
      sendReq(OpWrite, clintAddr(ClintMtimecmpOffset + ClintMtimecmpStride * i), randBits(64));
      sendReq(OpRead, clintAddr(ClintMtimecmpOffset + ClintMtimecmpStride * i), '0);
      sendReq(OpWrite, clintAddr(ClintMtimecmpOffset + ClintMtimecmpStride * i), '1);
    end
    sendReq(OpRead, clintAddr(ClintMtimeOffset), '0);
    repeat (9) @(negedge clk);
    sendReq(OpRead, clintAddr(ClintMtimeOffset), '0);
    for (int i = 0; i < NumHarts; i++) begin
      sendReq(OpWrite, clintAddr(ClintMtimecmpOffset + ClintMtimecmpStride * i), '0);
    end
    drain();
    waitIrqs("irqTimer_o", 1, '1);
    for (int i = 0; i < NumHarts; i++) begin
      sendReq(OpWrite, clintAddr(ClintMtimecmpOffset + ClintMtimecmpStride * i), '1);
    end
    drain();
    waitIrqs("irqTimer_o", 1, '0);

    //////////////////////////////////////////////////////////////////////
    // claim/complete on context 0, then enable masking

    irqSrc = NumIrqs'('b110);
    sendReq(OpWrite, plicAddr(PlicEnableOffset), '1);
    sendReq(OpRead, plicAddr(PlicEnableOffset), '0);
    drain();
    waitIrqs("irqExternal_o", 2, modelExt());
    // expect 1, 2, then 0
    for (int i = 0; i < 3; i++) begin
      sendReq(OpRead, plicAddr(PlicClaimOffset), '0);
    end
    drain();
    waitIrqs("irqExternal_o", 2, modelExt());
    sendReq(OpWrite, plicAddr(PlicClaimOffset), 64'd1);
    sendReq(OpWrite, plicAddr(PlicClaimOffset), 64'd2);
    sendReq(OpRead, plicAddr(PlicPendingOffset), '0);
    drain();
    waitIrqs("irqExternal_o", 2, modelExt());

    irqSrc = NumIrqs'('b1000);
    sendReq(OpWrite, plicAddr(PlicEnableOffset), '0);
    sendReq(OpWrite, plicAddr(PlicEnableOffset + PlicEnableStride), 64'h8);
    sendReq(OpRead, plicAddr(PlicPendingOffset), '0);
    sendReq(OpRead, plicAddr(PlicClaimOffset), '0);
    drain();
    waitIrqs("irqExternal_o", 2, modelExt());

    // back-to-back random traffic
    for (int i = 0; i < 48; i++) begin
      h  = int'(randBits(4)) % NumHarts;
      op = randBits(1) ? OpWrite : OpRead;
      case (randBits(3))
        0, 1:    a = clintAddr(ClintMsipOffset + ClintMsipStride * h);
        2:       a = clintAddr(ClintMtimecmpOffset + ClintMtimecmpStride * h);
        3:       a = plicAddr(PlicEnableOffset + PlicEnableStride * h);
        4:       a = clintAddr(ClintMtimeOffset);
        5:       a = plicAddr(PlicPendingOffset);
        default: a = unmappedAddr();
      endcase
      sendReq(op, a, randBits(64));
    end
    drain();

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+testbench
verilog/ioFabricPkg.sv
verilog/ioAddrDecode.sv
verilog/clintRegs.sv
verilog/plicRegs.sv
verilog/ioRespMux.sv
verilog/ioFabricTop.sv
testbench/ioFabricTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module ioFabricTb -f flist.f -o simv
	out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
